// File: logic/tgen_pkg.sv
//////////////////////////////////////////////////
// Shared types for the micro-DMA traffic generator
// Holds widths, opcodes, register map and bus structs
// Import it wherever one of these names is used
//////////////////////////////////////////////////

package tgen_pkg;

    // Word address and data widths of the shared memory
    localparam int TGEN_ADDR_W = 16;
    localparam int TGEN_DATA_W = 32;

    // Transform applied by the store engine
    typedef enum logic [1:0] {
        TG_PASS,
        TG_INVERT,
        TG_BSWAP
    } tgen_mode_e;

    // Register map of the configuration port
    typedef enum logic [2:0] {
        REG_SETUP,
        REG_SRC,
        REG_DST,
        REG_LEN,
        REG_STATUS
    } tgen_reg_e;

    // Setup word, enable in bit 1 and mode in bits 3 to 2
    typedef struct packed {
        logic [27:0] rsvd_hi;
        tgen_mode_e  mode;
        logic        en;
        logic        rsvd_lo;
    } tgen_setup_t;

    // One request on the shared memory port
    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [TGEN_ADDR_W-1:0] addr;
        logic [TGEN_DATA_W-1:0] wdata;
    } tgen_mem_req_t;

    // Job settings handed from the registers to both engines
    typedef struct packed {
        logic [TGEN_ADDR_W-1:0] src;
        logic [TGEN_ADDR_W-1:0] dst;
        logic [TGEN_ADDR_W-1:0] len;
        tgen_mode_e             mode;
    } tgen_job_t;

endpackage

// File: logic/tgen_cfg_regs.sv
//////////////////////////////////////////////////
// Configuration registers of the traffic generator
// Software writes setup, addresses and length here
// A nonzero LEN write starts a job, STATUS reports it
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tgen_cfg_regs #(
    parameter int MAX_LEN_W = 16
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    cfg_we_i,
    input  tgen_pkg::tgen_reg_e     cfg_addr_i,
    input  logic [31:0]             cfg_wdata_i,
    input  logic                    done_i,
    output logic [31:0]             cfg_rdata_o,
    output tgen_pkg::tgen_setup_t   setup_o,
    output tgen_pkg::tgen_job_t     job_o,
    output logic                    start_o,
    output logic                    busy_o
);

    import tgen_pkg::*;

    tgen_setup_t            setup_q;
    logic [TGEN_ADDR_W-1:0] src_q;
    logic [TGEN_ADDR_W-1:0] dst_q;
    logic [MAX_LEN_W-1:0]   len_q;
    logic                   start_q;
    logic                   done_q;
    logic                   busy_q;

    assign setup_o = setup_q;
    assign start_o = start_q;
    assign busy_o  = busy_q;

    // The mode travels with the job so the store engine sees one struct
    assign job_o.src  = src_q;
    assign job_o.dst  = dst_q;
    assign job_o.len  = TGEN_ADDR_W'(len_q);
    assign job_o.mode = setup_q.mode;

    // Read mux, purely combinational
    always_comb
    begin
        case (cfg_addr_i)
            REG_SETUP:  cfg_rdata_o = setup_q;
            REG_SRC:    cfg_rdata_o = 32'(src_q);
            REG_DST:    cfg_rdata_o = 32'(dst_q);
            REG_LEN:    cfg_rdata_o = 32'(len_q);
            REG_STATUS: cfg_rdata_o = {30'd0, busy_q, done_q};
            default:    cfg_rdata_o = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            setup_q <= '0;
            src_q   <= '0;
            dst_q   <= '0;
            len_q   <= '0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
            busy_q  <= 1'b0;
        end
        else
        begin
            start_q <= 1'b0;
            // The engine's done is stale in the start cycle, so it is ignored there
            if (busy_q && done_i && !start_q)
            begin
                done_q <= 1'b1;
                busy_q <= 1'b0;
            end
            if (cfg_we_i)
            begin
                case (cfg_addr_i)
                    REG_SETUP: setup_q <= cfg_wdata_i;
                    REG_SRC:   src_q   <= cfg_wdata_i[TGEN_ADDR_W-1:0];
                    REG_DST:   dst_q   <= cfg_wdata_i[TGEN_ADDR_W-1:0];
                    REG_LEN:
                    begin
                        len_q <= cfg_wdata_i[MAX_LEN_W-1:0];
                        // Zero length is stored but never launches a job
                        if (cfg_wdata_i[MAX_LEN_W-1:0] != '0)
                        begin
                            start_q <= 1'b1;
                            done_q  <= 1'b0;
                            busy_q  <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: logic/tgen_tx_fetch.sv
//////////////////////////////////////////////////
// Fetch engine, reads source words from memory
// Offers each word to the transmitter until taken
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tgen_tx_fetch #(
    parameter int MAX_LEN_W = 16
) (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                start_i,
    input  tgen_pkg::tgen_job_t                 job_i,
    input  logic                                mem_gnt_i,
    input  logic [tgen_pkg::TGEN_DATA_W-1:0]    mem_rdata_i,
    input  logic                                tx_ready_i,
    input  logic                                stall_i,
    output tgen_pkg::tgen_mem_req_t             mem_req_o,
    output logic [tgen_pkg::TGEN_DATA_W-1:0]    tx_data_o,
    output logic                                tx_valid_o
);

    import tgen_pkg::*;

    typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQ, FETCH_WAIT, FETCH_OFFER} fetch_state_e;

    fetch_state_e           state_q;
    fetch_state_e           state_d;
    logic [TGEN_ADDR_W-1:0] addr_q;
    logic [MAX_LEN_W-1:0]   cnt_q;
    logic [MAX_LEN_W-1:0]   cnt_nxt;
    logic [MAX_LEN_W-1:0]   len_w;
    logic [TGEN_DATA_W-1:0] data_q;
    logic                   take;

    assign len_w   = MAX_LEN_W'(job_i.len);
    assign cnt_nxt = cnt_q + 1'b1;

    // Back-pressure from the store buffer hides the word without losing it
    assign tx_valid_o = (state_q == FETCH_OFFER) && !stall_i;
    assign tx_data_o  = data_q;
    assign take       = tx_valid_o && tx_ready_i;

    // Read-only requester
    assign mem_req_o.req   = (state_q == FETCH_REQ);
    assign mem_req_o.we    = 1'b0;
    assign mem_req_o.addr  = addr_q;
    assign mem_req_o.wdata = '0;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE:  state_d = FETCH_IDLE;
            FETCH_REQ:   if (mem_gnt_i) state_d = FETCH_WAIT;
            // Read data is on the bus in this cycle
            FETCH_WAIT:  state_d = FETCH_OFFER;
            FETCH_OFFER: if (take) state_d = (cnt_nxt == len_w) ? FETCH_IDLE : FETCH_REQ;
            default:     state_d = FETCH_IDLE;
        endcase
        // A new job restarts the engine from any state
        if (start_i)
            state_d = FETCH_REQ;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            state_q <= FETCH_IDLE;
            addr_q  <= '0;
            cnt_q   <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (start_i)
            begin
                addr_q <= job_i.src;
                cnt_q  <= '0;
            end
            else if (take)
            begin
                addr_q <= addr_q + 1'b1;
                cnt_q  <= cnt_nxt;
            end
        end
    end

    // Holding register for the word under offer
    always_ff @(posedge clk_i)
    begin
        if (state_q == FETCH_WAIT)
            data_q <= mem_rdata_i;
    end

endmodule

// File: logic/tgen_tx.sv
//////////////////////////////////////////////////
// Transmit block of the traffic generator
// Takes a word on valid/ready and shows it on tx_o
// for one cycle, with busy_o high in that cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tgen_tx (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  tgen_pkg::tgen_setup_t               setup_i,
    input  logic [tgen_pkg::TGEN_DATA_W-1:0]    tx_data_i,
    input  logic                                tx_valid_i,
    output logic [tgen_pkg::TGEN_DATA_W-1:0]    tx_o,
    output logic                                busy_o,
    output logic                                tx_ready_o
);

    import tgen_pkg::*;

    typedef enum logic {TX_IDLE, TX_SEND} tx_state_e;

    tx_state_e              state_q;
    tx_state_e              state_d;
    logic [TGEN_DATA_W-1:0] data_q;
    logic                   take;

    // Ready only while idle and enabled, so one word per two cycles at most
    assign tx_ready_o = (state_q == TX_IDLE) && setup_i.en;
    assign take       = tx_valid_i && tx_ready_o;

    assign busy_o = (state_q == TX_SEND);
    // Output is forced to zero outside the send cycle
    assign tx_o   = busy_o ? data_q : '0;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            TX_IDLE: if (take) state_d = TX_SEND;
            TX_SEND: state_d = TX_IDLE;
            default: state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            state_q <= TX_IDLE;
        else if (setup_i.en)
            state_q <= state_d;
        else
            // Disabling drops straight back to idle
            state_q <= TX_IDLE;
    end

    // Word captured on the handshake edge
    always_ff @(posedge clk_i)
    begin
        if (take)
            data_q <= tx_data_i;
    end

endmodule

// File: logic/tgen_rx_store.sv
//////////////////////////////////////////////////
// Store engine, transforms each transmitted word
// Writes it to dst plus index and counts to done
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tgen_rx_store #(
    parameter int MAX_LEN_W = 16
) (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                start_i,
    input  tgen_pkg::tgen_job_t                 job_i,
    input  logic [tgen_pkg::TGEN_DATA_W-1:0]    tx_i,
    input  logic                                tx_busy_i,
    input  logic                                mem_gnt_i,
    output tgen_pkg::tgen_mem_req_t             mem_req_o,
    output logic                                stall_o,
    output logic                                done_o
);

    import tgen_pkg::*;

    logic [TGEN_DATA_W-1:0] buf_q;
    logic                   full_q;
    logic                   done_q;
    logic [MAX_LEN_W-1:0]   cnt_q;
    logic [MAX_LEN_W-1:0]   cnt_nxt;
    logic [MAX_LEN_W-1:0]   len_w;

    // Word transform selected by the mode field
    function automatic logic [TGEN_DATA_W-1:0] xform(
        input tgen_mode_e             mode,
        input logic [TGEN_DATA_W-1:0] w
    );
        case (mode)
            TG_INVERT: return ~w;
            TG_BSWAP:  return {w[7:0], w[15:8], w[23:16], w[31:24]};
            default:   return w;
        endcase
    endfunction

    assign len_w   = MAX_LEN_W'(job_i.len);
    assign cnt_nxt = cnt_q + 1'b1;

    // A full buffer both requests the write and holds off the fetch side
    assign stall_o = full_q;
    assign done_o  = done_q;

    assign mem_req_o.req   = full_q;
    assign mem_req_o.we    = 1'b1;
    assign mem_req_o.addr  = job_i.dst + TGEN_ADDR_W'(cnt_q);
    assign mem_req_o.wdata = buf_q;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            full_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end
        else if (start_i)
        begin
            full_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end
        else
        begin
            if (mem_gnt_i)
            begin
                full_q <= 1'b0;
                cnt_q  <= cnt_nxt;
                if (cnt_nxt == len_w)
                    done_q <= 1'b1;
            end
            // A new pulse refills the buffer and wins over the grant
            if (tx_busy_i)
                full_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (tx_busy_i)
            buf_q <= xform(job_i.mode, tx_i);
    end

endmodule

// File: logic/tgen_mem_arbiter.sv
//////////////////////////////////////////////////
// Round-robin arbiter for the shared memory port
// Fetch and store engines compete as equal peers
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tgen_mem_arbiter (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  tgen_pkg::tgen_mem_req_t     fetch_req_i,
    input  tgen_pkg::tgen_mem_req_t     store_req_i,
    input  logic                        mem_gnt_i,
    output logic                        fetch_gnt_o,
    output logic                        store_gnt_o,
    output tgen_pkg::tgen_mem_req_t     mem_req_o
);

    typedef enum logic {WIN_FETCH, WIN_STORE} winner_e;

    winner_e last_q;
    logic    sel_store;

    // Store wins when alone, or when fetch took the last grant
    assign sel_store = store_req_i.req && (!fetch_req_i.req || (last_q == WIN_FETCH));

    // With no request at all the fetch side is shown, its req is low anyway
    assign mem_req_o = sel_store ? store_req_i : fetch_req_i;

    // Grant goes only to the engine on the bus this cycle
    assign fetch_gnt_o = mem_gnt_i && fetch_req_i.req && !sel_store;
    assign store_gnt_o = mem_gnt_i && sel_store;

    //////////////////////////////////////////////////
    // Last winner, updated on every accepted request
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            last_q <= WIN_STORE;
        else if (mem_gnt_i && mem_req_o.req)
            last_q <= sel_store ? WIN_STORE : WIN_FETCH;
    end

endmodule

// File: logic/tgen_top.sv
//////////////////////////////////////////////////
// Top of the micro-DMA traffic generator
// Registers, fetch and store engines, transmitter
// and memory arbiter, joined by wires only
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tgen_top #(
    parameter int MAX_LEN_W = 16
) (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                cfg_we_i,
    input  tgen_pkg::tgen_reg_e                 cfg_addr_i,
    input  logic [31:0]                         cfg_wdata_i,
    input  logic                                mem_gnt_i,
    input  logic [tgen_pkg::TGEN_DATA_W-1:0]    mem_rdata_i,
    output logic [31:0]                         cfg_rdata_o,
    output tgen_pkg::tgen_mem_req_t             mem_req_o,
    output logic [tgen_pkg::TGEN_DATA_W-1:0]    tx_o,
    output logic                                tx_busy_o,
    output logic                                done_o
);

    import tgen_pkg::*;

    tgen_setup_t            setup;
    tgen_job_t              job;
    logic                   start;
    tgen_mem_req_t          fetch_req;
    tgen_mem_req_t          store_req;
    logic                   fetch_gnt;
    logic                   store_gnt;
    logic [TGEN_DATA_W-1:0] tx_data;
    logic                   tx_valid;
    logic                   tx_ready;
    logic                   stall;

    ////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////

    // The busy level is only seen through STATUS
    tgen_cfg_regs #(.MAX_LEN_W(MAX_LEN_W)) u_cfg (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
        .done_i(done_o), .cfg_rdata_o(cfg_rdata_o), .setup_o(setup),
        .job_o(job), .start_o(start), .busy_o()
    );

    ////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////

    tgen_tx_fetch #(.MAX_LEN_W(MAX_LEN_W)) u_fetch (
        .clk_i(clk_i), .rstn_i(rstn_i), .start_i(start), .job_i(job),
        .mem_gnt_i(fetch_gnt), .mem_rdata_i(mem_rdata_i),
        .tx_ready_i(tx_ready), .stall_i(stall),
        .mem_req_o(fetch_req), .tx_data_o(tx_data), .tx_valid_o(tx_valid)
    );

    tgen_tx u_tx (
        .clk_i(clk_i), .rstn_i(rstn_i), .setup_i(setup),
        .tx_data_i(tx_data), .tx_valid_i(tx_valid),
        .tx_o(tx_o), .busy_o(tx_busy_o), .tx_ready_o(tx_ready)
    );

    // Store engine reacts to the tx pulse itself
    tgen_rx_store #(.MAX_LEN_W(MAX_LEN_W)) u_store (
        .clk_i(clk_i), .rstn_i(rstn_i), .start_i(start), .job_i(job),
        .tx_i(tx_o), .tx_busy_i(tx_busy_o), .mem_gnt_i(store_gnt),
        .mem_req_o(store_req), .stall_o(stall), .done_o(done_o)
    );

    tgen_mem_arbiter u_arb (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .fetch_req_i(fetch_req), .store_req_i(store_req), .mem_gnt_i(mem_gnt_i),
        .fetch_gnt_o(fetch_gnt), .store_gnt_o(store_gnt), .mem_req_o(mem_req_o)
    );

endmodule

// File: verif/tgen_tb.sv
//////////////////////////////////////////////////
// Testbench for the micro-DMA traffic generator
// Models the shared memory with random grant stalls,
// runs jobs in every mode and checks tx and memory
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tgen_tb;

    import tgen_pkg::*;

    // Word count over all jobs sizes the watchdog
    localparam int TOTAL_WORDS     = 52;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_WORDS * 4 + 1000;

    logic                   clk_i;
    logic                   rstn_i;
    logic                   cfg_we;
    tgen_reg_e              cfg_addr;
    logic [31:0]            cfg_wdata;
    logic [31:0]            cfg_rdata;
    logic                   mem_gnt;
    logic [TGEN_DATA_W-1:0] mem_rdata;
    tgen_mem_req_t          mem_req;
    logic [TGEN_DATA_W-1:0] tx_data;
    logic                   tx_busy;
    logic                   done;

    logic [31:0]            mem [0:65535];
    integer                 seed;

    // Job in progress as seen by the compare process and the memory model
    logic [15:0]            cur_src;
    logic [15:0]            cur_dst;
    int                     cur_len;
    tgen_mode_e             cur_mode;
    int                     tx_cnt;
    int                     wr_cnt;
    int                     err_cnt;
    int                     check_cnt;

    tgen_top #(.MAX_LEN_W(16)) dut0 (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
        .mem_gnt_i(mem_gnt), .mem_rdata_i(mem_rdata), .cfg_rdata_o(cfg_rdata),
        .mem_req_o(mem_req), .tx_o(tx_data), .tx_busy_o(tx_busy), .done_o(done)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Expected store result built from the mode rules
    function automatic logic [31:0] ref_xform(input tgen_mode_e mode, input logic [31:0] w);
        logic [31:0] r;
        int          b;
        r = w;
        if (mode == TG_INVERT)
            r = ~w;
        else if (mode == TG_BSWAP)
            for (b = 0; b < 4; b++)
                r[8*b +: 8] = w[8*(3-b) +: 8];
        return r;
    endfunction

    function automatic logic [31:0] setup_word(input logic en, input tgen_mode_e mode);
        tgen_setup_t s;
        s      = '0;
        s.en   = en;
        s.mode = mode;
        return s;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Write is sampled by the DUT on the second edge
    task automatic cfg_write(input tgen_reg_e addr, input logic [31:0] data);
        @(posedge clk_i);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk_i);
        cfg_we    <= 1'b0;
    endtask

    task automatic read_status(output logic [31:0] v);
        cfg_addr <= REG_STATUS;
        @(posedge clk_i);
        v = cfg_rdata;
    endtask

    task automatic start_job(input logic [15:0] src, input logic [15:0] dst,
                             input int len, input tgen_mode_e mode);
        cur_src  = src;
        cur_dst  = dst;
        cur_len  = len;
        cur_mode = mode;
        tx_cnt   = 0;
        wr_cnt   = 0;
        cfg_write(REG_SRC, 32'(src));
        cfg_write(REG_DST, 32'(dst));
        cfg_write(REG_LEN, 32'(len));
    endtask

    // Waits for done, then checks counts and the destination area
    task automatic finish_job();
        int i;
        repeat (2) @(posedge clk_i);
        while (!done)
            @(posedge clk_i);
        // Done must not come before the last write
        check("write count at done_o", 32'(wr_cnt), 32'(cur_len));
        repeat (8) @(posedge clk_i);
        check("tx_o pulse count", 32'(tx_cnt), 32'(cur_len));
        check("write count", 32'(wr_cnt), 32'(cur_len));
        for (i = 0; i < cur_len; i++)
            check("mem dst word", mem[cur_dst + 16'(i)],
                  ref_xform(cur_mode, mem[cur_src + 16'(i)]));
    endtask

    //////////////////////////////////////////////////
    // Memory model with a random grant pattern
    //////////////////////////////////////////////////

    initial
    begin
        int a;
        seed = 32'h4d77aff9;
        // Pattern covers every address bit so misplaced words show up
        for (a = 0; a < 65536; a++)
            mem[a] = (32'(a) * 32'h9e3779b1) ^ 32'h0f1e2d3c;
        mem_gnt   = 1'b0;
        mem_rdata = '0;
        forever
        begin
            @(posedge clk_i);
            if (rstn_i && mem_gnt && mem_req.req)
            begin
                if (mem_req.we)
                begin
                    check("mem_req_o.addr", 32'(mem_req.addr), 32'(cur_dst + 16'(wr_cnt)));
                    mem[mem_req.addr] = mem_req.wdata;
                    wr_cnt++;
                end
                else
                    mem_rdata <= mem[mem_req.addr];
            end
            // Grant about three cycles in four
            mem_gnt <= (($random(seed) & 3) != 0);
        end
    end

    // Each tx_o pulse must carry the next source word in address order
    always @(posedge clk_i)
    begin
        if (rstn_i && tx_busy)
        begin
            check("tx_o", tx_data, mem[cur_src + 16'(tx_cnt)]);
            tx_cnt++;
        end
        else if (rstn_i)
            check("tx_o idle", tx_data, 32'h0);
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the jobs did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        logic [31:0] st;
        rstn_i    = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = REG_SETUP;
        cfg_wdata = '0;
        cur_src   = '0;
        cur_dst   = '0;
        cur_len   = 0;
        cur_mode  = TG_PASS;
        tx_cnt    = 0;
        wr_cnt    = 0;
        err_cnt   = 0;
        check_cnt = 0;
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);

        // Quiet outputs straight after reset
        check("done_o", 32'(done), 32'h0);
        check("tx_busy_o", 32'(tx_busy), 32'h0);
        check("mem_req_o.req", 32'(mem_req.req), 32'h0);
        read_status(st);
        check("STATUS", st, 32'h0);

        cfg_write(REG_SETUP, setup_word(1'b1, TG_PASS));
        start_job(16'h1000, 16'h4000, 20, TG_PASS);
        finish_job();
        read_status(st);
        check("STATUS", st, 32'h1);

        // A new LEN write clears done and sets busy
        cfg_write(REG_SETUP, setup_word(1'b1, TG_INVERT));
        start_job(16'h1100, 16'h4100, 12, TG_INVERT);
        read_status(st);
        check("STATUS", st, 32'h2);
        finish_job();

        cfg_write(REG_SETUP, setup_word(1'b1, TG_BSWAP));
        start_job(16'h1200, 16'h4200, 12, TG_BSWAP);
        finish_job();

        // With en low the job sits pending until en is set
        cfg_write(REG_SETUP, setup_word(1'b0, TG_INVERT));
        start_job(16'h1300, 16'h4300, 8, TG_INVERT);
        repeat (60) @(posedge clk_i);
        check("tx_o pulse count", 32'(tx_cnt), 32'h0);
        check("write count", 32'(wr_cnt), 32'h0);
        read_status(st);
        check("STATUS", st, 32'h2);
        cfg_write(REG_SETUP, setup_word(1'b1, TG_INVERT));
        finish_job();

        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: tgen.f
logic/tgen_pkg.sv
logic/tgen_cfg_regs.sv
logic/tgen_tx_fetch.sv
logic/tgen_tx.sv
logic/tgen_rx_store.sv
logic/tgen_mem_arbiter.sv
logic/tgen_top.sv
verif/tgen_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tgen_tb -f tgen.f -o tgen_sim
./obj_dir/tgen_sim > sim.log
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
